/* ether_pkg.sv */
`default_nettype none

package ether_pkg;

    localparam int rxbuf_awidth = 6;
    localparam int txbuf_awidth = 6;

    // Receive buffer layout: size word at address 1, payload from address 2.
    localparam logic [rxbuf_awidth-1:0] rxbuf_size_addr = rxbuf_awidth'(1);
    localparam logic [rxbuf_awidth-1:0] rxbuf_data_addr = rxbuf_awidth'(2);

    localparam int tx_period = 200;
    localparam int tx_cnt_width = $clog2(tx_period);
    localparam logic [tx_cnt_width-1:0] tx_cnt_last = tx_cnt_width'(tx_period - 1);

    localparam logic [31:0] txbuf_word0 = 32'h0a01_a8c0; // Destination IP, LSB first.
    localparam logic [31:0] txbuf_word1 = 32'h0457_04d2; // Source and destination port.
    localparam logic [31:0] txbuf_word2 = 32'h0000_0007; // Payload length in bytes.
    localparam logic [31:0] txbuf_word3 = 32'h626f_6f66;
    localparam logic [31:0] txbuf_word4 = 32'h000a_7261;

    localparam int txbuf_hdr_words = 3;
    // The last header word carries the payload length.
    localparam logic [txbuf_awidth-1:0] txbuf_len_addr = txbuf_awidth'(txbuf_hdr_words - 1);

    localparam logic [15:0] led_red_max = 16'd10;
    localparam logic [15:0] led_green_max = 16'd20;

    typedef enum logic [2:0] {
        rx_idle,
        rx_data,
        rx_flush,
        rx_size,
        rx_handoff
    } rx_state_t;

    typedef enum logic [1:0] {
        tx_idle,
        tx_fetch,
        tx_send,
        tx_done
    } tx_state_t;

endpackage

`default_nettype wire

/* udp_host_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module udp_host_ctrl (
    input  wire                               clk_int,
    input  wire                               rst_n_int,
    input  wire [ether_pkg::rxbuf_awidth-1:0] rxbuf_addr,
    input  wire                               rxbuf_we,
    input  wire [31:0]                        rxbuf_wdata,
    input  wire                               rxbuf_cpu_grant,
    output logic                              rxbuf_cpu_rel,
    input  wire [ether_pkg::txbuf_awidth-1:0] txbuf_addr,
    input  wire                               txbuf_cpu_grant,
    output logic                              txbuf_cpu_rel,
    output logic [31:0]                       txbuf_rdata,
    output wire                               led_r,
    output wire                               led_g,
    output wire                               led_b
);

    logic [ether_pkg::tx_cnt_width-1:0] tx_cnt;
    logic [15:0]                        last_rx_size;

    always_ff @(posedge clk_int or negedge rst_n_int) begin
        if (!rst_n_int) begin
            tx_cnt        <= '0;
            txbuf_cpu_rel <= 1'b0;
        end else begin
            if (tx_cnt == ether_pkg::tx_cnt_last) begin
                tx_cnt        <= '0;
                txbuf_cpu_rel <= txbuf_cpu_grant; // A busy stack skips this slot.
            end else begin
                tx_cnt        <= tx_cnt + 1'b1;
                txbuf_cpu_rel <= 1'b0;
            end
        end
    end

    // Registered table, so data follows the address by one cycle.
    always_ff @(posedge clk_int) begin
        case (txbuf_addr)
            0:       txbuf_rdata <= ether_pkg::txbuf_word0;
            1:       txbuf_rdata <= ether_pkg::txbuf_word1;
            2:       txbuf_rdata <= ether_pkg::txbuf_word2;
            3:       txbuf_rdata <= ether_pkg::txbuf_word3;
            4:       txbuf_rdata <= ether_pkg::txbuf_word4;
            default: txbuf_rdata <= 32'h0;
        endcase
    end

    always_ff @(posedge clk_int or negedge rst_n_int) begin
        if (!rst_n_int) begin
            rxbuf_cpu_rel <= 1'b0;
            last_rx_size  <= '0;
        end else begin
            rxbuf_cpu_rel <= rxbuf_cpu_grant && !rxbuf_cpu_rel; // One pulse per grant.
            if (rxbuf_we && rxbuf_addr == ether_pkg::rxbuf_size_addr) begin
                last_rx_size <= rxbuf_wdata[31:16];
            end
        end
    end

    assign led_r = (last_rx_size != '0) && (last_rx_size <= ether_pkg::led_red_max);
    assign led_g = (last_rx_size > ether_pkg::led_red_max) &&
                   (last_rx_size <= ether_pkg::led_green_max);
    assign led_b = (last_rx_size > ether_pkg::led_green_max);

    // The rx path must drop grant on the pulse, or a second release would follow.
    a_rx_grant_drop : assert property (@(posedge clk_int) disable iff (!rst_n_int)
        rxbuf_cpu_rel |=> !rxbuf_cpu_grant)
        else $error("rxbuf_cpu_grant still high after release");

    a_tx_rel_single : assert property (@(posedge clk_int) disable iff (!rst_n_int)
        txbuf_cpu_rel |=> !txbuf_cpu_rel)
        else $error("txbuf_cpu_rel high for two cycles");

endmodule

`default_nettype wire

/* udp_rx_path.sv */
`timescale 1ns/10ps
`default_nettype none

module udp_rx_path (
    input  wire                                clk_int,
    input  wire                                rst_n_int,
    input  wire [3:0]                          phy_rxd,
    input  wire                                phy_rx_dv,
    input  wire                                phy_rx_er,
    output logic [ether_pkg::rxbuf_awidth-1:0] rxbuf_addr,
    output logic                               rxbuf_we,
    output logic [31:0]                        rxbuf_wdata,
    output logic                               rxbuf_cpu_grant,
    input  wire                                rxbuf_cpu_rel
);

    ether_pkg::rx_state_t              state;
    logic                              dv_q;
    logic                              nib_phase;
    logic [3:0]                        nib_lo;
    logic [7:0]                        rx_byte;
    logic [31:0]                       word_buf;
    logic [15:0]                       byte_cnt;
    logic [ether_pkg::rxbuf_awidth-1:0] wr_addr;
    logic                              start;
    logic                              take_nib;
    logic                              byte_done;
    logic                              word_full;

    // Only a fresh rise of dv opens a frame, so a frame cut short is skipped whole.
    assign start     = (state == ether_pkg::rx_idle) && phy_rx_dv && !dv_q && !phy_rx_er;
    assign take_nib  = (state == ether_pkg::rx_data) && phy_rx_dv && !phy_rx_er;
    assign byte_done = take_nib && nib_phase;
    assign word_full = byte_done && (byte_cnt[1:0] == 2'd3);
    assign rx_byte   = {phy_rxd, nib_lo};

    always_ff @(posedge clk_int or negedge rst_n_int) begin
        if (!rst_n_int) begin
            state           <= ether_pkg::rx_idle;
            dv_q            <= 1'b0;
            nib_phase       <= 1'b0;
            byte_cnt        <= '0;
            wr_addr         <= '0;
            rxbuf_we        <= 1'b0;
            rxbuf_cpu_grant <= 1'b0;
        end else begin
            dv_q     <= phy_rx_dv;
            rxbuf_we <= 1'b0;
            if (start) begin
                nib_phase <= 1'b1;
            end else if (take_nib) begin
                nib_phase <= !nib_phase;
            end
            case (state)
                ether_pkg::rx_idle: begin
                    if (start) begin
                        byte_cnt <= '0;
                        wr_addr  <= ether_pkg::rxbuf_data_addr;
                        state    <= ether_pkg::rx_data;
                    end
                end
                ether_pkg::rx_data: begin
                    if (phy_rx_er) begin
                        state <= ether_pkg::rx_idle; // Bad frame, no size word.
                    end else if (!phy_rx_dv) begin
                        state <= ether_pkg::rx_flush;
                    end else if (byte_done && wr_addr == '0) begin
                        state <= ether_pkg::rx_idle; // Buffer full.
                    end else if (byte_done) begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (word_full) begin
                            rxbuf_we <= 1'b1;
                            wr_addr  <= wr_addr + 1'b1;
                        end
                    end
                end
                ether_pkg::rx_flush: begin
                    rxbuf_we <= (byte_cnt[1:0] != 2'd0);
                    state    <= ether_pkg::rx_size;
                end
                ether_pkg::rx_size: begin
                    rxbuf_we <= 1'b1;
                    state    <= ether_pkg::rx_handoff;
                end
                default: begin
                    rxbuf_cpu_grant <= !rxbuf_cpu_rel;
                    if (rxbuf_cpu_rel) begin
                        state <= ether_pkg::rx_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_int) begin
        if (start || (take_nib && !nib_phase)) begin
            nib_lo <= phy_rxd;
        end
        if (start || word_full) begin
            word_buf <= '0; // Zeros pad a short last word.
        end else if (byte_done) begin
            word_buf[8*byte_cnt[1:0] +: 8] <= rx_byte;
        end
        if (word_full) begin
            rxbuf_addr  <= wr_addr;
            rxbuf_wdata <= {rx_byte, word_buf[23:0]};
        end else if (state == ether_pkg::rx_flush) begin
            rxbuf_addr  <= wr_addr;
            rxbuf_wdata <= word_buf;
        end else if (state == ether_pkg::rx_size) begin
            rxbuf_addr  <= ether_pkg::rxbuf_size_addr;
            rxbuf_wdata <= {byte_cnt, 16'h0000};
        end
    end

    a_no_write_granted : assert property (@(posedge clk_int) disable iff (!rst_n_int)
        rxbuf_cpu_grant |-> !rxbuf_we)
        else $error("rx buffer written while granted to host");

endmodule

`default_nettype wire

/* udp_tx_path.sv */
`timescale 1ns/10ps
`default_nettype none

module udp_tx_path (
    input  wire                                clk_int,
    input  wire                                rst_n_int,
    input  wire                                txbuf_cpu_rel,
    input  wire [31:0]                         txbuf_rdata,
    output logic [ether_pkg::txbuf_awidth-1:0] txbuf_addr,
    output wire                                txbuf_cpu_grant,
    output logic [3:0]                         phy_txd,
    output logic                               phy_tx_en
);

    ether_pkg::tx_state_t state;
    logic [2:0]           nib_cnt;
    logic [16:0]          rem;
    logic [31:0]          shreg;
    logic                 load;
    logic [3:0]           nib_out;

    assign txbuf_cpu_grant = (state == ether_pkg::tx_idle);

    // A new word enters every eighth nibble; its address went out one word earlier.
    assign load = (state == ether_pkg::tx_fetch) ||
                  ((state == ether_pkg::tx_send) && (nib_cnt == 3'd0));
    assign nib_out = load ? txbuf_rdata[3:0] : shreg[3:0];

    always_ff @(posedge clk_int or negedge rst_n_int) begin
        if (!rst_n_int) begin
            state      <= ether_pkg::tx_idle;
            txbuf_addr <= '0;
            nib_cnt    <= '0;
            rem        <= '0;
            phy_txd    <= '0;
            phy_tx_en  <= 1'b0;
        end else begin
            case (state)
                ether_pkg::tx_idle: begin
                    if (txbuf_cpu_rel) begin
                        state <= ether_pkg::tx_fetch;
                    end
                end
                ether_pkg::tx_fetch: begin
                    // Word 0 has been on txbuf_rdata since the frame before.
                    phy_txd    <= nib_out;
                    phy_tx_en  <= 1'b1;
                    txbuf_addr <= txbuf_addr + 1'b1;
                    nib_cnt    <= 3'd1;
                    rem        <= '1; // The real count is known at word 2.
                    state      <= ether_pkg::tx_send;
                end
                ether_pkg::tx_send: begin
                    phy_txd <= nib_out;
                    nib_cnt <= nib_cnt + 1'b1;
                    rem     <= rem - 1'b1;
                    if (load) begin
                        txbuf_addr <= txbuf_addr + 1'b1;
                        if (txbuf_addr == ether_pkg::txbuf_len_addr) begin
                            rem <= {txbuf_rdata[15:0], 1'b0} + 17'd7;
                        end
                    end
                    if (rem == 17'd1) begin
                        state <= ether_pkg::tx_done; // Last nibble goes out now.
                    end
                end
                default: begin
                    phy_txd    <= '0;
                    phy_tx_en  <= 1'b0;
                    txbuf_addr <= '0;
                    state      <= ether_pkg::tx_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk_int) begin
        if (load) begin
            shreg <= txbuf_rdata >> 4;
        end else begin
            shreg <= shreg >> 4;
        end
    end

    a_en_not_granted : assert property (@(posedge clk_int) disable iff (!rst_n_int)
        !(phy_tx_en && txbuf_cpu_grant))
        else $error("phy_tx_en high while buffer granted to host");

endmodule

`default_nettype wire

/* ether_top.sv */
`timescale 1ns/10ps
`default_nettype none

module ether_top (
    input  wire       clk_int,
    input  wire       rst_n_int,
    input  wire [3:0] phy_rxd,
    input  wire       phy_rx_dv,
    input  wire       phy_rx_er,
    output wire [3:0] phy_txd,
    output wire       phy_tx_en,
    output wire       led_r,
    output wire       led_g,
    output wire       led_b
);

    wire [ether_pkg::rxbuf_awidth-1:0] rxbuf_addr;
    wire                               rxbuf_we;
    wire [31:0]                        rxbuf_wdata;
    wire                               rxbuf_cpu_grant;
    wire                               rxbuf_cpu_rel;
    wire [ether_pkg::txbuf_awidth-1:0] txbuf_addr;
    wire [31:0]                        txbuf_rdata;
    wire                               txbuf_cpu_grant;
    wire                               txbuf_cpu_rel;

    udp_host_ctrl i_host (
        .clk_int         (clk_int),
        .rst_n_int       (rst_n_int),
        .rxbuf_addr      (rxbuf_addr),
        .rxbuf_we        (rxbuf_we),
        .rxbuf_wdata     (rxbuf_wdata),
        .rxbuf_cpu_grant (rxbuf_cpu_grant),
        .rxbuf_cpu_rel   (rxbuf_cpu_rel),
        .txbuf_addr      (txbuf_addr),
        .txbuf_cpu_grant (txbuf_cpu_grant),
        .txbuf_cpu_rel   (txbuf_cpu_rel),
        .txbuf_rdata     (txbuf_rdata),
        .led_r           (led_r),
        .led_g           (led_g),
        .led_b           (led_b)
    );

    udp_rx_path i_rx (
        .clk_int         (clk_int),
        .rst_n_int       (rst_n_int),
        .phy_rxd         (phy_rxd),
        .phy_rx_dv       (phy_rx_dv),
        .phy_rx_er       (phy_rx_er),
        .rxbuf_addr      (rxbuf_addr),
        .rxbuf_we        (rxbuf_we),
        .rxbuf_wdata     (rxbuf_wdata),
        .rxbuf_cpu_grant (rxbuf_cpu_grant),
        .rxbuf_cpu_rel   (rxbuf_cpu_rel)
    );

    udp_tx_path i_tx (
        .clk_int         (clk_int),
        .rst_n_int       (rst_n_int),
        .txbuf_cpu_rel   (txbuf_cpu_rel),
        .txbuf_rdata     (txbuf_rdata),
        .txbuf_addr      (txbuf_addr),
        .txbuf_cpu_grant (txbuf_cpu_grant),
        .phy_txd         (phy_txd),
        .phy_tx_en       (phy_tx_en)
    );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic clk_int
);

    initial begin
        clk_int = 1'b0;
    end

    always begin
        #4 clk_int = ~clk_int; // Half of the 8 ns period.
    end

endmodule

`default_nettype wire

/* tb_ether_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_ether_top;

    localparam logic [31:0] rng_seed = 32'h768f_f74d;
    localparam int watchdog_limit = 20 * ether_pkg::tx_period;
    localparam int tx_frames_needed = 4;
    // Bytes go LSB first and nibbles low first, so nibble n sits at bits 4n+3:4n.
    localparam logic [159:0] tx_image = {ether_pkg::txbuf_word4, ether_pkg::txbuf_word3,
                                         ether_pkg::txbuf_word2, ether_pkg::txbuf_word1,
                                         ether_pkg::txbuf_word0};
    localparam int tx_frame_nibs =
        2 * (4 * ether_pkg::txbuf_hdr_words + int'(ether_pkg::txbuf_word2[15:0]));

    logic        clk_int;
    logic        rst_n_int;
    logic [3:0]  phy_rxd;
    logic        phy_rx_dv;
    logic        phy_rx_er;
    logic [3:0]  phy_txd;
    logic        phy_tx_en;
    logic        led_r;
    logic        led_g;
    logic        led_b;

    logic [31:0] rng_state;
    logic [31:0] rx_ref_mem [0:63];
    int          rx_len;
    logic        rx_started;
    logic        led_check;
    logic        bad_frame;
    logic [2:0]  exp_leds;
    int          cycles_since_reset;
    int          tx_nib_cnt;
    int          tx_gap;
    int          tx_frames_seen;
    int          rx_grants_seen;
    int          watchdog_cnt;
    logic        tx_en_q;
    logic        tx_rise_seen;
    logic        rx_grant_q;

    tb_clock_gen i_clk (
        .clk_int (clk_int)
    );

    ether_top i_dut (
        .clk_int   (clk_int),
        .rst_n_int (rst_n_int),
        .phy_rxd   (phy_rxd),
        .phy_rx_dv (phy_rx_dv),
        .phy_rx_er (phy_rx_er),
        .phy_txd   (phy_txd),
        .phy_tx_en (phy_tx_en),
        .led_r     (led_r),
        .led_g     (led_g),
        .led_b     (led_b)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [3:0] tx_ref_nibble(input int idx);
        if (idx < 0 || idx >= tx_frame_nibs) begin
            return 4'h0;
        end
        return tx_image[4 * idx +: 4];
    endfunction

    // One-hot {red, green, blue} for a datagram of n bytes.
    function automatic logic [2:0] led_class(input int n);
        if (n == 0) begin
            return 3'b000;
        end else if (n <= int'(ether_pkg::led_red_max)) begin
            return 3'b100;
        end else if (n <= int'(ether_pkg::led_green_max)) begin
            return 3'b010;
        end
        return 3'b001;
    endfunction

    task automatic stop_on_failure(input string line);
        $display("%s", line);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string msg);
        stop_on_failure($sformatf("Mismatch at time %0t: %s", $time, msg));
    endtask

    // Sends len random bytes as MII nibbles; with_error raises rx_er on the middle byte.
    task automatic send_rx_frame(input int len, input logic with_error);
        logic [7:0] b;
        led_check  <= with_error;
        bad_frame  <= with_error;
        rx_started <= 1'b1;
        rx_len = len;
        for (int i = 0; i < 64; i++) begin
            rx_ref_mem[i] = 32'h0;
        end
        for (int i = 0; i < len; i++) begin
            rng_state = xorshift32(rng_state);
            b = rng_state[7:0];
            rx_ref_mem[2 + i / 4][8 * (i % 4) +: 8] = b; // Payload starts at address 2.
            phy_rx_er <= with_error && (i == len / 2);
            phy_rx_dv <= 1'b1;
            phy_rxd   <= b[3:0];
            @(posedge clk_int);
            phy_rxd <= b[7:4];
            @(posedge clk_int);
        end
        phy_rx_dv <= 1'b0;
        phy_rx_er <= 1'b0;
        phy_rxd   <= 4'h0;
        @(posedge clk_int);
    endtask

    task automatic await_rx_handoff();
        while (!i_dut.rxbuf_cpu_grant) begin
            @(posedge clk_int);
        end
        while (i_dut.rxbuf_cpu_grant) begin
            @(posedge clk_int);
        end
    endtask

    task automatic expect_leds_for(input int len);
        exp_leds  <= led_class(len);
        led_check <= 1'b1;
        repeat (4) @(posedge clk_int);
    endtask

    always_ff @(posedge clk_int or negedge rst_n_int) begin
        if (!rst_n_int) begin
            cycles_since_reset <= 0;
            tx_en_q            <= 1'b0;
            tx_nib_cnt         <= 0;
            tx_gap             <= 0;
            tx_rise_seen       <= 1'b0;
            tx_frames_seen     <= 0;
            rx_grant_q         <= 1'b0;
            rx_grants_seen     <= 0;
        end else begin
            cycles_since_reset <= cycles_since_reset + 1;
            tx_en_q            <= phy_tx_en;
            rx_grant_q         <= i_dut.rxbuf_cpu_grant;
            if (phy_tx_en) begin
                tx_nib_cnt <= tx_nib_cnt + 1;
            end else begin
                tx_nib_cnt <= 0;
            end
            if (phy_tx_en && !tx_en_q) begin
                tx_gap       <= 1;
                tx_rise_seen <= 1'b1;
            end else begin
                tx_gap <= tx_gap + 1;
            end
            if (!phy_tx_en && tx_en_q) begin
                tx_frames_seen <= tx_frames_seen + 1;
            end
            if (i_dut.rxbuf_cpu_grant && !rx_grant_q) begin
                rx_grants_seen <= rx_grants_seen + 1;
            end
        end
    end

    always @(posedge clk_int) begin
        watchdog_cnt <= watchdog_cnt + 1;
        if (watchdog_cnt >= watchdog_limit) begin
            stop_on_failure("Timeout: the test did not finish within the cycle limit.");
        end
    end

    a_tx_quiet : assert property (@(posedge clk_int) disable iff (!rst_n_int)
        (cycles_since_reset < ether_pkg::tx_period) |-> !phy_tx_en)
        else report_mismatch("phy_tx_en high before the first transmit period");

    a_leds_dark : assert property (@(posedge clk_int) disable iff (!rst_n_int)
        !rx_started |-> ({led_r, led_g, led_b} == 3'b000))
        else report_mismatch("LED lit before any frame was received");

    a_tx_nibble : assert property (@(posedge clk_int) disable iff (!rst_n_int)
        phy_tx_en |-> (phy_txd == tx_ref_nibble(tx_nib_cnt)))
        else report_mismatch("phy_txd differs from the transmit table");

    a_tx_not_long : assert property (@(posedge clk_int) disable iff (!rst_n_int)
        phy_tx_en |-> (tx_nib_cnt < tx_frame_nibs))
        else report_mismatch("transmit frame longer than expected");

    a_tx_length : assert property (@(posedge clk_int) disable iff (!rst_n_int)
        (!phy_tx_en && tx_en_q) |-> (tx_nib_cnt == tx_frame_nibs))
        else report_mismatch("transmit frame nibble count wrong");

    a_tx_spacing : assert property (@(posedge clk_int) disable iff (!rst_n_int)
        (phy_tx_en && !tx_en_q && tx_rise_seen) |-> (tx_gap == ether_pkg::tx_period))
        else report_mismatch("transmit frames not one period apart");

    a_led_class : assert property (@(posedge clk_int) disable iff (!rst_n_int)
        led_check |-> ({led_r, led_g, led_b} == exp_leds))
        else report_mismatch("LED pattern does not match the last good frame size");

    a_no_grant_bad : assert property (@(posedge clk_int) disable iff (!rst_n_int)
        bad_frame |-> !i_dut.rxbuf_cpu_grant)
        else report_mismatch("receive buffer handed over after a bad frame");

    a_rx_size_word : assert property (@(posedge clk_int) disable iff (!rst_n_int)
        (i_dut.rxbuf_we && i_dut.rxbuf_addr == 6'd1) |-> (i_dut.rxbuf_wdata[31:16] == rx_len))
        else report_mismatch("size word differs from the bytes sent");

    a_rx_payload : assert property (@(posedge clk_int) disable iff (!rst_n_int)
        (i_dut.rxbuf_we && i_dut.rxbuf_addr >= 6'd2) |->
            (i_dut.rxbuf_wdata == rx_ref_mem[i_dut.rxbuf_addr]))
        else report_mismatch("receive buffer word differs from the bytes sent");

    initial begin
        rst_n_int    = 1'b0;
        phy_rxd      = 4'h0;
        phy_rx_dv    = 1'b0;
        phy_rx_er    = 1'b0;
        rx_started   = 1'b0;
        led_check    = 1'b0;
        bad_frame    = 1'b0;
        exp_leds     = 3'b000;
        rx_len       = 0;
        watchdog_cnt = 0;
        rng_state    = rng_seed;
        for (int i = 0; i < 64; i++) begin
            rx_ref_mem[i] = 32'h0;
        end
        repeat (16) @(posedge clk_int);
        rst_n_int <= 1'b1;
        repeat (40) @(posedge clk_int);
        send_rx_frame(5, 1'b0);
        await_rx_handoff();
        expect_leds_for(5);
        send_rx_frame(15, 1'b0);
        await_rx_handoff();
        expect_leds_for(15);
        send_rx_frame(40, 1'b0);
        await_rx_handoff();
        expect_leds_for(40);
        send_rx_frame(15, 1'b1);
        repeat (40) @(posedge clk_int); // Well past where a size word and grant would come.
        bad_frame <= 1'b0;
        while (tx_frames_seen < tx_frames_needed) begin
            @(posedge clk_int);
        end
        if (rx_grants_seen == 3) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            stop_on_failure($sformatf("Expected 3 receive handoffs but saw %0d.",
                                      rx_grants_seen));
        end
    end

endmodule

`default_nettype wire

/* list.f */
ether_pkg.sv
udp_host_ctrl.sv
udp_rx_path.sv
udp_tx_path.sv
ether_top.sv
tb_clock_gen.sv
tb_ether_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
    --top-module tb_ether_top -f list.f -o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
    echo "Simulation passed."
else
    echo "Simulation failed, see sim.log."
    exit 1
fi
